//--- Makefile
# Verilator simulation of the floating-point execute unit

sim:
	verilator --binary --timing --assert -f fp_alu.f --top-module fp_alu_tb -Mdir obj_dir
	./obj_dir/Vfp_alu_tb > sim.log 2>&1 || echo "tests failed" >> sim.log
	cat sim.log
	! grep -q "tests failed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

//--- arith/fp_adder.sv
`default_nettype none
`timescale 1ns/1ns

module fp_adder import fp_alu_pkg::*; (
  input  wire  [WORD_W-1:0] a,
  input  wire  [WORD_W-1:0] b,
  input  wire               subtract,
  output logic [WORD_W-1:0] sum
);

  logic               a_s, b_s;
  logic [EXP_W-1:0]   a_e, b_e;
  logic [MAN_W-1:0]   a_m, b_m;
  logic               a_nan, b_nan;
  logic               a_inf, b_inf;
  logic               a_zero, b_zero;
  logic [MAN_W:0]     a_sig, b_sig;
  logic [WORD_W-2:0]  a_mag, b_mag;

  logic               swap;
  logic               big_s;
  logic [EXP_W-1:0]   big_e, sml_e;
  logic [MAN_W:0]     big_sig, sml_sig;
  logic [EXP_W-1:0]   exp_diff;
  logic [MAN_W:0]     sml_al;
  logic               eff_sub;
  logic [MAN_W+1:0]   raw;

  logic [4:0]         lead;
  logic [MAN_W+1:0]   norm;
  logic [MAN_W-1:0]   mant_n;
  logic signed [EXP_W+1:0] exp_n;

  ////////////////////////////////////////
  // Operand unpack
  ////////////////////////////////////////
  assign a_s = a[WORD_W-1];
  assign b_s = b[WORD_W-1] ^ subtract;  // Subtract flips B
  assign a_e = a[WORD_W-2 -: EXP_W];
  assign b_e = b[WORD_W-2 -: EXP_W];
  assign a_m = a[MAN_W-1:0];
  assign b_m = b[MAN_W-1:0];

  assign a_nan  = (a_e == EXP_MAX) && (a_m != '0);
  assign b_nan  = (b_e == EXP_MAX) && (b_m != '0);
  assign a_inf  = (a_e == EXP_MAX) && (a_m == '0);
  assign b_inf  = (b_e == EXP_MAX) && (b_m == '0);
  assign a_zero = (a_e == '0);  // Subnormals count as zero
  assign b_zero = (b_e == '0);

  // Hidden bit restored and flushed operands zeroed
  assign a_sig = a_zero ? '0 : {1'b1, a_m};
  assign b_sig = b_zero ? '0 : {1'b1, b_m};
  assign a_mag = a_zero ? '0 : a[WORD_W-2:0];
  assign b_mag = b_zero ? '0 : b[WORD_W-2:0];

  ////////////////////////////////////////
  // Align and add
  ////////////////////////////////////////
  assign swap    = (b_mag > a_mag);
  assign big_s   = swap ? b_s   : a_s;
  assign big_e   = swap ? b_e   : a_e;
  assign sml_e   = swap ? a_e   : b_e;
  assign big_sig = swap ? b_sig : a_sig;
  assign sml_sig = swap ? a_sig : b_sig;

  assign exp_diff = big_e - sml_e;
  assign sml_al   = sml_sig >> exp_diff;  // Shifted-out bits are lost
  assign eff_sub  = a_s ^ b_s;

  assign raw = eff_sub ? ({1'b0, big_sig} - {1'b0, sml_al})
                       : ({1'b0, big_sig} + {1'b0, sml_al});

  // Position of the leading one
  always_comb begin
    lead = '0;
    for (int i = 0; i <= MAN_W + 1; i++) begin
      if (raw[i]) lead = 5'(i);
    end
  end

  assign norm   = raw << (5'(MAN_W + 1) - lead);
  assign mant_n = norm[MAN_W:1];  // Truncate below 23 bits
  assign exp_n  = $signed({2'b00, big_e}) + $signed({5'b00000, lead})
                - (EXP_W+2)'(MAN_W);

  ////////////////////////////////////////
  // Special cases and packing
  ////////////////////////////////////////
  always_comb begin
    if (a_nan || b_nan || (a_inf && b_inf && (a_s != b_s))) begin
      sum = CANON_NAN;
    end else if (a_inf) begin
      sum = {a_s, EXP_MAX, {MAN_W{1'b0}}};
    end else if (b_inf) begin
      sum = {b_s, EXP_MAX, {MAN_W{1'b0}}};
    end else if (raw == '0) begin
      sum = {a_s & b_s, {(WORD_W-1){1'b0}}};  // Negative only if both are
    end else if (exp_n >= $signed({2'b00, EXP_MAX})) begin
      sum = {big_s, EXP_MAX, {MAN_W{1'b0}}};  // Overflow
    end else if (exp_n <= 0) begin
      sum = {big_s, {(WORD_W-1){1'b0}}};      // Flush to zero
    end else begin
      sum = {big_s, exp_n[EXP_W-1:0], mant_n};
    end
  end

endmodule

`default_nettype wire

//--- arith/fp_arith.sv
`default_nettype none
`timescale 1ns/1ns

module fp_arith import fp_alu_pkg::*; (
  input  wire               clk,
  input  wire               op_valid,
  input  wire fp_op_e       op,
  input  wire  [WORD_W-1:0] a,
  input  wire  [WORD_W-1:0] b,
  output logic [WORD_W-1:0] arith_res
);

  logic              subtract;
  logic [WORD_W-1:0] sum;
  logic [WORD_W-1:0] product;

  assign subtract = (op == OP_SUB);

  fp_adder i_adder (
    .a        (a),
    .b        (b),
    .subtract (subtract),
    .sum      (sum)
  );

  fp_multiplier i_mult (
    .a       (a),
    .b       (b),
    .product (product)
  );

  // Stage 1 result register
  always_ff @(posedge clk) begin
    if (op_valid) begin
      arith_res <= (op == OP_MUL) ? product : sum;  // Adder covers the rest
    end
  end

endmodule

`default_nettype wire

//--- arith/fp_multiplier.sv
`default_nettype none
`timescale 1ns/1ns

module fp_multiplier import fp_alu_pkg::*; (
  input  wire  [WORD_W-1:0] a,
  input  wire  [WORD_W-1:0] b,
  output logic [WORD_W-1:0] product
);

  logic                     a_s, b_s, p_s;
  logic [EXP_W-1:0]         a_e, b_e;
  logic [MAN_W-1:0]         a_m, b_m;
  logic                     a_nan, b_nan;
  logic                     a_inf, b_inf;
  logic                     a_zero, b_zero;
  logic [2*MAN_W+1:0]       prod;
  logic                     prod_hi;
  logic [MAN_W-1:0]         mant;
  logic signed [EXP_W+1:0]  exp_sum;

  assign a_s = a[WORD_W-1];
  assign b_s = b[WORD_W-1];
  assign p_s = a_s ^ b_s;
  assign a_e = a[WORD_W-2 -: EXP_W];
  assign b_e = b[WORD_W-2 -: EXP_W];
  assign a_m = a[MAN_W-1:0];
  assign b_m = b[MAN_W-1:0];

  assign a_nan  = (a_e == EXP_MAX) && (a_m != '0);
  assign b_nan  = (b_e == EXP_MAX) && (b_m != '0);
  assign a_inf  = (a_e == EXP_MAX) && (a_m == '0);
  assign b_inf  = (b_e == EXP_MAX) && (b_m == '0);
  assign a_zero = (a_e == '0);  // Zero or subnormal
  assign b_zero = (b_e == '0);

  ////////////////////////////////////////
  // Significand product
  ////////////////////////////////////////
  assign prod    = {1'b1, a_m} * {1'b1, b_m};
  assign prod_hi = prod[2*MAN_W+1];  // Product in [2,4)

  // One-place normalize, then truncate
  assign mant = prod_hi ? prod[2*MAN_W -: MAN_W] : prod[2*MAN_W-1 -: MAN_W];

  assign exp_sum = $signed({2'b00, a_e}) + $signed({2'b00, b_e})
                 + $signed({{(EXP_W+1){1'b0}}, prod_hi})
                 - (EXP_W+2)'(EXP_BIAS);

  always_comb begin
    if (a_nan || b_nan) begin
      product = CANON_NAN;
    end else if ((a_inf && b_zero) || (b_inf && a_zero)) begin
      product = CANON_NAN;
    end else if (a_inf || b_inf) begin
      product = {p_s, EXP_MAX, {MAN_W{1'b0}}};
    end else if (a_zero || b_zero) begin
      product = {p_s, {(WORD_W-1){1'b0}}};
    end else if (exp_sum >= $signed({2'b00, EXP_MAX})) begin
      product = {p_s, EXP_MAX, {MAN_W{1'b0}}};  // Overflow to infinity
    end else if (exp_sum <= 0) begin
      product = {p_s, {(WORD_W-1){1'b0}}};      // Underflow
    end else begin
      product = {p_s, exp_sum[EXP_W-1:0], mant};
    end
  end

endmodule

`default_nettype wire

//--- common/fp_alu_pkg.sv
`default_nettype none

package fp_alu_pkg;

  ////////////////////////////////////////
  // IEEE single field layout
  ////////////////////////////////////////
  localparam int EXP_W    = 8;
  localparam int MAN_W    = 23;
  localparam int WORD_W   = 32;
  localparam int EXP_BIAS = 127;

  // All-ones exponent of infinity and NaN
  localparam logic [EXP_W-1:0] EXP_MAX = 8'hFF;

  // Quiet NaN returned by add and multiply
  localparam logic [WORD_W-1:0] CANON_NAN = 32'h7FC0_0000;

  ////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////
  typedef enum logic [3:0] {
    OP_ADD   = 4'b0000,
    OP_MOV   = 4'b0001,
    OP_MUL   = 4'b0010,
    OP_CLASS = 4'b0011,
    OP_EQ    = 4'b1100,
    OP_LT    = 4'b1101,
    OP_LE    = 4'b1110,
    OP_SUB   = 4'b1111   // A minus B
  } fp_op_e;

  // Class code of operand A
  typedef enum logic [2:0] {
    CL_INF      = 3'd0,  // Either sign
    CL_NEG_NORM = 3'd1,
    CL_NEG_SUB  = 3'd2,
    CL_NEG_ZERO = 3'd3,
    CL_POS_ZERO = 3'd4,
    CL_POS_SUB  = 3'd5,
    CL_POS_NORM = 3'd6,
    CL_NAN      = 3'd7
  } fp_class_e;

endpackage

`default_nettype wire

//--- fp_alu.f
common/fp_alu_pkg.sv
arith/fp_adder.sv
arith/fp_multiplier.sv
arith/fp_arith.sv
hw/fp_compare_class.sv
hw/fp_result_select.sv
hw/fp_alu.sv
tests/fp_alu_chk.sv
tests/fp_alu_tb.sv

//--- hw/fp_alu.sv
`default_nettype none
`timescale 1ns/1ns

module fp_alu import fp_alu_pkg::*; (
  input  wire               clk,
  input  wire               reset,
  input  wire               op_valid,
  input  wire fp_op_e       op,
  input  wire  [WORD_W-1:0] a,
  input  wire  [WORD_W-1:0] b,
  output logic              out_valid,
  output logic [WORD_W-1:0] out,
  output logic              alu_err
);

  // Registered results of the two parallel parts
  logic [WORD_W-1:0] arith_res;
  logic              eq_q;
  logic              lt_q;
  logic              le_q;
  fp_class_e         class_q;

  fp_arith i_arith (
    .clk       (clk),
    .op_valid  (op_valid),
    .op        (op),
    .a         (a),
    .b         (b),
    .arith_res (arith_res)
  );

  fp_compare_class i_cmp (
    .clk      (clk),
    .op_valid (op_valid),
    .a        (a),
    .b        (b),
    .eq_q     (eq_q),
    .lt_q     (lt_q),
    .le_q     (le_q),
    .class_q  (class_q)
  );

  fp_result_select i_sel (
    .clk       (clk),
    .reset     (reset),
    .op_valid  (op_valid),
    .op        (op),
    .a         (a),
    .arith_res (arith_res),
    .eq_q      (eq_q),
    .lt_q      (lt_q),
    .le_q      (le_q),
    .class_q   (class_q),
    .out_valid (out_valid),
    .out       (out),
    .alu_err   (alu_err)
  );

endmodule

`default_nettype wire

//--- hw/fp_compare_class.sv
`default_nettype none
`timescale 1ns/1ns

module fp_compare_class import fp_alu_pkg::*; (
  input  wire               clk,
  input  wire               op_valid,
  input  wire  [WORD_W-1:0] a,
  input  wire  [WORD_W-1:0] b,
  output logic              eq_q,
  output logic              lt_q,
  output logic              le_q,
  output fp_class_e         class_q
);

  fp_class_e a_cl, b_cl;
  logic      any_nan;
  logic      eq, lt;

  // Field based class of one operand
  function automatic fp_class_e classify(input logic [WORD_W-1:0] x);
    logic             s;
    logic [EXP_W-1:0] e;
    logic [MAN_W-1:0] m;
    s = x[WORD_W-1];
    e = x[WORD_W-2 -: EXP_W];
    m = x[MAN_W-1:0];
    if (e == EXP_MAX) begin
      classify = (m == '0) ? CL_INF : CL_NAN;
    end else if (e != '0) begin
      classify = s ? CL_NEG_NORM : CL_POS_NORM;
    end else if (m != '0) begin
      classify = s ? CL_NEG_SUB : CL_POS_SUB;
    end else begin
      classify = s ? CL_NEG_ZERO : CL_POS_ZERO;
    end
  endfunction

  assign a_cl    = classify(a);
  assign b_cl    = classify(b);
  assign any_nan = (a_cl == CL_NAN) || (b_cl == CL_NAN);

  ////////////////////////////////////////
  // Sign-magnitude ordering
  ////////////////////////////////////////
  assign eq = !any_nan && (a == b);

  always_comb begin
    if (any_nan) begin
      lt = 1'b0;  // Unordered
    end else if (a[WORD_W-1] != b[WORD_W-1]) begin
      lt = a[WORD_W-1];  // Negative below positive, even for zeros
    end else if (!a[WORD_W-1]) begin
      lt = (a[WORD_W-2:0] < b[WORD_W-2:0]);
    end else begin
      lt = (a[WORD_W-2:0] > b[WORD_W-2:0]);  // Larger magnitude is smaller
    end
  end

  always_ff @(posedge clk) begin
    if (op_valid) begin
      eq_q    <= eq;
      lt_q    <= lt;
      le_q    <= lt | eq;
      class_q <= a_cl;
    end
  end

endmodule

`default_nettype wire

//--- hw/fp_result_select.sv
`default_nettype none
`timescale 1ns/1ns

module fp_result_select import fp_alu_pkg::*; (
  input  wire               clk,
  input  wire               reset,
  input  wire               op_valid,
  input  wire fp_op_e       op,
  input  wire  [WORD_W-1:0] a,
  input  wire  [WORD_W-1:0] arith_res,
  input  wire               eq_q,
  input  wire               lt_q,
  input  wire               le_q,
  input  wire fp_class_e    class_q,
  output logic              out_valid,
  output logic [WORD_W-1:0] out,
  output logic              alu_err
);

  logic              valid_s1;
  fp_op_e            op_s1;
  logic [WORD_W-1:0] a_s1;
  logic [WORD_W-1:0] sel_res;
  logic              sel_undef;

  // Stage 1 control
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_s1 <= 1'b0;
    end else begin
      valid_s1 <= op_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (op_valid) begin
      op_s1 <= op;
      a_s1  <= a;
    end
  end

  always_comb begin
    sel_undef = 1'b0;
    case (op_s1)
      OP_ADD, OP_SUB, OP_MUL: sel_res = arith_res;
      OP_EQ:    sel_res = {{(WORD_W-1){1'b0}}, eq_q};
      OP_LT:    sel_res = {{(WORD_W-1){1'b0}}, lt_q};
      OP_LE:    sel_res = {{(WORD_W-1){1'b0}}, le_q};
      OP_CLASS: sel_res = {{(WORD_W-$bits(fp_class_e)){1'b0}}, class_q};
      OP_MOV:   sel_res = a_s1;
      default: begin
        sel_res   = a_s1;  // Undefined code passes A
        sel_undef = 1'b1;
      end
    endcase
  end

  // Stage 2 output registers
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
      alu_err   <= 1'b0;
    end else begin
      out_valid <= valid_s1;
      alu_err   <= valid_s1 & sel_undef;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_s1) begin
      out <= sel_res;  // Holds while idle
    end
  end

endmodule

`default_nettype wire

//--- tests/fp_alu_chk.sv
`default_nettype none
`timescale 1ns/1ns

module fp_alu_chk (
  input wire clk,
  input wire reset,
  input wire op_valid,
  input wire out_valid,
  input wire alu_err
);

  ////////////////////////////////////////
  // Strobe timing
  ////////////////////////////////////////
  a_issue_returns: assert property (@(posedge clk) disable iff (reset)
    op_valid |-> ##2 out_valid)
    else $error("op_valid not followed by out_valid two cycles later");

  // No result without an issue
  a_result_issued: assert property (@(posedge clk) disable iff (reset)
    out_valid |-> $past(op_valid, 2))
    else $error("out_valid without op_valid two cycles earlier");

  a_err_valid: assert property (@(posedge clk) alu_err |-> out_valid)
    else $error("alu_err raised without out_valid");

  a_reset_quiet: assert property (@(posedge clk) reset |=> !out_valid)
    else $error("out_valid high in the cycle after reset");  // Pipeline cleared

endmodule

bind fp_alu fp_alu_chk i_chk (
  .clk       (clk),
  .reset     (reset),
  .op_valid  (op_valid),
  .out_valid (out_valid),
  .alu_err   (alu_err)
);

`default_nettype wire

//--- tests/fp_alu_tb.sv
`default_nettype none
`timescale 1ns/1ns

module fp_alu_tb import fp_alu_pkg::*; ();

  localparam int N_OPS      = 1200;
  localparam int MAX_CYCLES = 2 * N_OPS + 600;  // Idle gaps, reset and drain

  logic              clk = 1'b0;
  logic              reset;
  logic              op_valid;
  fp_op_e            op;
  logic [WORD_W-1:0] a;
  logic [WORD_W-1:0] b;
  wire               out_valid;
  wire  [WORD_W-1:0] out;
  wire               alu_err;

  logic [31:0]       lfsr = 32'h3b04;
  logic [3:0]        code_q[$];
  logic [WORD_W-1:0] exp_q[$];
  logic [3:0]        cmp_code;
  logic [WORD_W-1:0] cmp_exp;
  int                value_errs = 0;
  int                other_errs = 0;
  int                cycles = 0;
  logic [3:0]        op_list [8] = '{OP_ADD, OP_MOV, OP_MUL, OP_CLASS,
                                     OP_EQ, OP_LT, OP_LE, OP_SUB};
  logic [31:0]       class_pats [8] = '{32'h7F80_0000, 32'hBF80_0000, 32'h8000_0001,
                                        32'h8000_0000, 32'h0000_0000, 32'h0000_0001,
                                        32'h3F80_0000, 32'h7FC0_0000};

  fp_alu i_dut (
    .clk       (clk),
    .reset     (reset),
    .op_valid  (op_valid),
    .op        (op),
    .a         (a),
    .b         (b),
    .out_valid (out_valid),
    .out       (out),
    .alu_err   (alu_err)
  );

  always #20 clk = ~clk;

  ////////////////////////////////////////
  // Stimulus source
  ////////////////////////////////////////
  // Fibonacci step, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic rand_operand(output logic [31:0] v);
    logic [31:0] kind;
    logic [31:0] r;
    take_bits(3, kind);
    take_bits(32, r);
    case (kind)
      0: v = r;
      1: v = {r[31], 8'd0, r[22:0] & {23{r[24]}}};     // Zero or subnormal
      2: v = {r[31], 8'hFF, r[22:0] & {23{r[25]}}};    // Infinity or NaN
      3: v = {r[31], 4'd0, r[26:23] | 4'd1, r[22:0]};  // Near underflow
      4: v = {r[31], 4'hF, r[26:23] & 4'hE, r[22:0]};  // Near overflow
      default: v = {r[31], 3'b011, r[27:23], r[22:0]};
    endcase
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////
  function automatic logic is_nan(input logic [31:0] x);
    return (x[30:23] == 8'hFF) && (x[22:0] != 0);
  endfunction

  function automatic logic is_inf(input logic [31:0] x);
    return (x[30:23] == 8'hFF) && (x[22:0] == 0);
  endfunction

  function automatic logic is_defined(input logic [3:0] code);
    return code inside {OP_ADD, OP_MOV, OP_MUL, OP_CLASS, OP_EQ, OP_LT, OP_LE, OP_SUB};
  endfunction

  // Sum of x and y, with the sign of y already effective
  function automatic logic [31:0] ref_add(input logic [31:0] x, input logic [31:0] y);
    int          ex;
    int          ey;
    int          e;
    logic        s;
    logic [24:0] mx;
    logic [24:0] my;
    logic [24:0] r;
    ex = int'(x[30:23]);
    ey = int'(y[30:23]);
    if (is_nan(x) || is_nan(y) || (is_inf(x) && is_inf(y) && x[31] != y[31])) begin
      return CANON_NAN;
    end
    if (is_inf(x)) return x;
    if (is_inf(y)) return y;
    mx = (ex == 0) ? '0 : {2'b01, x[22:0]};
    my = (ey == 0) ? '0 : {2'b01, y[22:0]};
    if ((ey != 0) && ((ex == 0) || (y[30:0] > x[30:0]))) begin
      s  = y[31];
      e  = ey;
      mx = mx >> (ey - ex);  // Alignment drops the low bits
      r  = (x[31] != y[31]) ? my - mx : my + mx;
    end else begin
      s  = x[31];
      e  = ex;
      my = my >> (ex - ey);
      r  = (x[31] != y[31]) ? mx - my : mx + my;
    end
    if (r == 0) return {x[31] & y[31], 31'd0};
    while (r[24]) begin
      r = r >> 1;
      e = e + 1;
    end
    while (!r[23]) begin
      r = r << 1;
      e = e - 1;
    end
    if (e >= 255) return {s, 8'hFF, 23'd0};
    if (e <= 0) return {s, 31'd0};
    return {s, e[7:0], r[22:0]};
  endfunction

  function automatic logic [31:0] ref_mul(input logic [31:0] x, input logic [31:0] y);
    logic        s;
    int          e;
    logic [47:0] p;
    s = x[31] ^ y[31];
    if (is_nan(x) || is_nan(y)) return CANON_NAN;
    if ((is_inf(x) && y[30:23] == 0) || (is_inf(y) && x[30:23] == 0)) return CANON_NAN;
    if (is_inf(x) || is_inf(y)) return {s, 8'hFF, 23'd0};
    if (x[30:23] == 0 || y[30:23] == 0) return {s, 31'd0};
    p = 48'({1'b1, x[22:0]}) * 48'({1'b1, y[22:0]});
    e = int'(x[30:23]) + int'(y[30:23]) - EXP_BIAS;
    if (p[47]) begin
      e = e + 1;
    end else begin
      p = p << 1;
    end
    if (e >= 255) return {s, 8'hFF, 23'd0};
    if (e <= 0) return {s, 31'd0};
    return {s, e[7:0], p[46:24]};
  endfunction

  function automatic logic ref_lt(input logic [31:0] x, input logic [31:0] y);
    if (is_nan(x) || is_nan(y)) return 1'b0;
    if (x[31] != y[31]) return x[31];
    return x[31] ? (x[30:0] > y[30:0]) : (x[30:0] < y[30:0]);
  endfunction

  function automatic fp_class_e ref_class(input logic [31:0] x);
    if (is_nan(x)) return CL_NAN;
    if (is_inf(x)) return CL_INF;
    if (x[30:23] != 0) return x[31] ? CL_NEG_NORM : CL_POS_NORM;
    if (x[22:0] != 0) return x[31] ? CL_NEG_SUB : CL_POS_SUB;
    return x[31] ? CL_NEG_ZERO : CL_POS_ZERO;
  endfunction

  function automatic logic [31:0] fp_ref_op(input logic [3:0] code,
                                            input logic [31:0] x, input logic [31:0] y);
    logic eq;
    eq = !is_nan(x) && !is_nan(y) && (x == y);
    case (code)
      OP_ADD:   return ref_add(x, y);
      OP_SUB:   return ref_add(x, y ^ 32'h8000_0000);
      OP_MUL:   return ref_mul(x, y);
      OP_EQ:    return {31'd0, eq};
      OP_LT:    return {31'd0, ref_lt(x, y)};
      OP_LE:    return {31'd0, ref_lt(x, y) || eq};
      OP_CLASS: return {29'd0, ref_class(x)};
      default:  return x;  // MOV and undefined codes
    endcase
  endfunction

  ////////////////////////////////////////
  // Checking
  ////////////////////////////////////////
  task automatic check_word(input fp_op_e op_tag, input logic [31:0] exp_w,
                            input logic [31:0] act_w, input logic exp_err, input logic act_err);
    string name;
    name = is_defined(op_tag) ? op_tag.name() : "undefined";
    if (act_w !== exp_w) begin
      value_errs++;
      $display("[ERROR] %s: expected out %h, actual %h", name, exp_w, act_w);
    end
    if (act_err !== exp_err) begin
      value_errs++;
      $display("[ERROR] %s: expected alu_err %b, actual %b", name, exp_err, act_err);
    end
  endtask

  task automatic check_class(input fp_class_e exp_c, input fp_class_e act_c);
    if (act_c !== exp_c) begin
      value_errs++;
      $display("[ERROR] class: expected %s, actual %0d", exp_c.name(), act_c);
    end
  endtask

  always @(negedge clk) begin
    if (out_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        other_errs++;
        $display("Result strobe seen with no operation outstanding");
      end else begin
        cmp_code = code_q.pop_front();
        cmp_exp  = exp_q.pop_front();
        check_word(fp_op_e'(cmp_code), cmp_exp, out, !is_defined(cmp_code), alu_err);
        if (cmp_code == OP_CLASS) begin
          check_class(fp_class_e'(cmp_exp[2:0]), fp_class_e'(out[2:0]));
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Run did not finish within %0d cycles", MAX_CYCLES);
      $display("tests failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Driving
  ////////////////////////////////////////
  task automatic issue(input logic [3:0] code, input logic [31:0] x, input logic [31:0] y);
    @(posedge clk);
    #2;
    op_valid = 1'b1;
    op       = fp_op_e'(code);
    a        = x;
    b        = y;
    code_q.push_back(code);
    exp_q.push_back(fp_ref_op(code, x, y));
  endtask

  task automatic idle();
    @(posedge clk);
    #2;
    op_valid = 1'b0;
  endtask

  initial begin
    logic [31:0] x;
    logic [31:0] y;
    logic [31:0] pick;
    reset    = 1'b1;
    op_valid = 1'b0;
    op       = OP_ADD;
    a        = '0;
    b        = '0;
    repeat (4) @(posedge clk);
    #2;
    reset = 1'b0;

    issue(OP_SUB, 32'h7F80_0000, 32'h7F80_0000);  // Infinity minus infinity
    issue(OP_MUL, 32'hFF80_0000, 32'h0000_0000);
    issue(OP_LT, 32'h7FC0_0001, 32'h3F80_0000);
    issue(OP_LT, 32'h8000_0000, 32'h0000_0000);   // Negative zero below positive
    issue(OP_SUB, 32'h4040_0000, 32'h4040_0000);
    issue(OP_ADD, 32'h4B80_0000, 32'h3F80_0000);
    for (int i = 0; i < 8; i++) begin
      issue(OP_CLASS, class_pats[i], 32'h0);
    end

    // Random mix, strobes back to back with idle gaps
    for (int n = 0; n < N_OPS; n++) begin
      take_bits(2, pick);
      if (pick == 0) idle();
      rand_operand(x);
      take_bits(2, pick);
      case (pick)
        0: y = x;
        1: y = x ^ 32'h8000_0000;
        default: rand_operand(y);
      endcase
      take_bits(4, pick);
      if (pick < 14) begin
        issue(op_list[pick[2:0]], x, y);
      end else begin
        take_bits(4, pick);
        issue(pick[3:0], x, y);
      end
    end
    idle();
    while (exp_q.size() != 0) @(posedge clk);

    $display("Errors: %0d value, %0d other", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
